// File: dot_prod.f
+incdir+hdl
hdl/dot_prod_pkg.sv
hdl/sample_pair_align.sv
hdl/cpx_multiply.sv
hdl/dot_accumulate.sv
hdl/result_saturate.sv
hdl/dot_prod_top.sv
tests/dot_prod_properties.sv
tests/dot_prod_tb.sv

// File: hdl/cpx_multiply.sv
`default_nettype none

module cpx_multiply (
   input  wire                    clk,
   input  wire                    arst_n_i,
   input  wire                    ready_i,
   input  wire                    pair_valid_i,
   input  dot_prod_pkg::sample_t  xi_i,
   input  dot_prod_pkg::sample_t  xq_i,
   input  dot_prod_pkg::sample_t  yi_i,
   input  dot_prod_pkg::sample_t  yq_i,
   output logic                   prod_valid_o,
   output dot_prod_pkg::product_t prod_i_o,
   output dot_prod_pkg::product_t prod_q_o
);

   logic                   mul_valid;       // stage one occupied
   dot_prod_pkg::product_t p_ii, p_qq;      // real partials
   dot_prod_pkg::product_t p_iq, p_qi;      // imaginary partials

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mul_valid    <= 1'b0;
         prod_valid_o <= 1'b0;
      end else if (ready_i) begin
         mul_valid    <= pair_valid_i;
         prod_valid_o <= mul_valid;
      end
   end

   // stage one, four signed multiplies
   always_ff @(posedge clk) begin
      if (ready_i) begin
         p_ii <= xi_i * yi_i;
         p_qq <= xq_i * yq_i;
         p_iq <= xi_i * yq_i;
         p_qi <= xq_i * yi_i;
      end
   end

   // stage two
   always_ff @(posedge clk) begin
      if (ready_i) begin
         prod_i_o <= p_ii - p_qq;
         prod_q_o <= p_iq + p_qi;
      end
   end

endmodule

`default_nettype wire

// File: hdl/dot_accumulate.sv
`default_nettype none

`include "dot_prod_cfg.svh"

module dot_accumulate (
   input  wire                    clk,
   input  wire                    arst_n_i,
   input  wire                    ready_i,
   input  wire                    prod_valid_i,
   input  dot_prod_pkg::product_t prod_i_i,
   input  dot_prod_pkg::product_t prod_q_i,
   output logic                   sum_valid_o,
   output dot_prod_pkg::acc_t     sum_i_o,
   output dot_prod_pkg::acc_t     sum_q_o
);

   localparam logic [`DP_CNT_W-1:0] last_cnt = `DP_LENGTH - 1;

   logic [`DP_CNT_W-1:0] term_cnt;
   logic                 last_term;
   dot_prod_pkg::acc_t   ext_i, ext_q;

   // sign extension into the accumulator width
   assign ext_i = dot_prod_pkg::acc_t'(prod_i_i);
   assign ext_q = dot_prod_pkg::acc_t'(prod_q_i);

   assign last_term = (term_cnt == last_cnt);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         term_cnt    <= '0;
         sum_valid_o <= 1'b0;
      end else if (ready_i) begin
         sum_valid_o <= prod_valid_i && last_term;
         if (prod_valid_i) begin
            if (last_term)
               term_cnt <= '0;  // wrap after DP_LENGTH terms
            else
               term_cnt <= term_cnt + 1'b1;
         end
      end
   end

   // the sum register is the output, so the last term and the flag land together
   always_ff @(posedge clk) begin
      if (ready_i && prod_valid_i) begin
         if (term_cnt == '0) begin  // first term starts fresh
            sum_i_o <= ext_i;
            sum_q_o <= ext_q;
         end else begin
            sum_i_o <= sum_i_o + ext_i;
            sum_q_o <= sum_q_o + ext_q;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/dot_prod_cfg.svh
`ifndef DOT_PROD_CFG_SVH
`define DOT_PROD_CFG_SVH

// signed width of each real or imaginary input part
`define DP_SAMPLE_W 12

// one product part, two sample widths plus one
`define DP_PROD_W 25

// products summed into one dot product
`define DP_LENGTH 5

// term counter, must hold DP_LENGTH - 1
`define DP_CNT_W 3

// product width plus guard bits for DP_LENGTH terms
`define DP_ACC_W 28

// saturated output part
`define DP_RES_W 24

`endif

// File: hdl/dot_prod_pkg.sv
`default_nettype none

`include "dot_prod_cfg.svh"

package dot_prod_pkg;

   typedef logic signed [`DP_SAMPLE_W-1:0] sample_t;  // one input part
   typedef logic signed [`DP_PROD_W-1:0]   product_t;
   typedef logic signed [`DP_ACC_W-1:0]    acc_t;     // running sum
   typedef logic signed [`DP_RES_W-1:0]    result_t;

   // pairing stage, which stream is waiting for its partner
   typedef enum logic [1:0] {
      PAIR_EMPTY,
      PAIR_HAVE_X,
      PAIR_HAVE_Y
   } pair_state_e;

endpackage

`default_nettype wire

// File: hdl/dot_prod_top.sv
`default_nettype none

module dot_prod_top (
   input  wire                   clk,
   input  wire                   arst_n_i,
   input  wire                   ready_i,
   input  wire                   x_valid_i,
   input  dot_prod_pkg::sample_t xi_i,
   input  dot_prod_pkg::sample_t xq_i,
   input  wire                   y_valid_i,
   input  dot_prod_pkg::sample_t yi_i,
   input  dot_prod_pkg::sample_t yq_i,
   output logic                  result_valid_o,
   output dot_prod_pkg::result_t result_i_o,
   output dot_prod_pkg::result_t result_q_o
);

   logic                   pair_valid;
   dot_prod_pkg::sample_t  pxi, pxq, pyi, pyq;
   logic                   prod_valid;
   dot_prod_pkg::product_t prod_i, prod_q;
   logic                   sum_valid;
   dot_prod_pkg::acc_t     sum_i, sum_q;

   sample_pair_align align_i (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .ready_i      (ready_i),
      .x_valid_i    (x_valid_i),
      .xi_i         (xi_i),
      .xq_i         (xq_i),
      .y_valid_i    (y_valid_i),
      .yi_i         (yi_i),
      .yq_i         (yq_i),
      .pair_valid_o (pair_valid),
      .pxi_o        (pxi),
      .pxq_o        (pxq),
      .pyi_o        (pyi),
      .pyq_o        (pyq)
   );

   cpx_multiply mult_i (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .ready_i      (ready_i),
      .pair_valid_i (pair_valid),
      .xi_i         (pxi),
      .xq_i         (pxq),
      .yi_i         (pyi),
      .yq_i         (pyq),
      .prod_valid_o (prod_valid),
      .prod_i_o     (prod_i),
      .prod_q_o     (prod_q)
   );

   dot_accumulate acc_i (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .ready_i      (ready_i),
      .prod_valid_i (prod_valid),
      .prod_i_i     (prod_i),
      .prod_q_i     (prod_q),
      .sum_valid_o  (sum_valid),
      .sum_i_o      (sum_i),
      .sum_q_o      (sum_q)
   );

   result_saturate sat_i (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .ready_i        (ready_i),
      .sum_valid_i    (sum_valid),
      .sum_i_i        (sum_i),
      .sum_q_i        (sum_q),
      .result_valid_o (result_valid_o),
      .result_i_o     (result_i_o),
      .result_q_o     (result_q_o)
   );

endmodule

`default_nettype wire

// File: hdl/result_saturate.sv
`default_nettype none

`include "dot_prod_cfg.svh"

module result_saturate (
   input  wire                   clk,
   input  wire                   arst_n_i,
   input  wire                   ready_i,
   input  wire                   sum_valid_i,
   input  dot_prod_pkg::acc_t    sum_i_i,
   input  dot_prod_pkg::acc_t    sum_q_i,
   output logic                  result_valid_o,
   output dot_prod_pkg::result_t result_i_o,
   output dot_prod_pkg::result_t result_q_o
);

   localparam dot_prod_pkg::result_t res_max = {1'b0, {(`DP_RES_W-1){1'b1}}};
   localparam dot_prod_pkg::result_t res_min = {1'b1, {(`DP_RES_W-1){1'b0}}};

   function automatic dot_prod_pkg::result_t clamp(input dot_prod_pkg::acc_t v);
      logic [`DP_ACC_W-`DP_RES_W:0] top;  // bits that must all match the sign
      top = v[`DP_ACC_W-1:`DP_RES_W-1];
      if (&top || ~|top)
         return v[`DP_RES_W-1:0];
      else if (v[`DP_ACC_W-1])
         return res_min;
      else
         return res_max;
   endfunction

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         result_valid_o <= 1'b0;
         result_i_o     <= '0;
         result_q_o     <= '0;
      end else if (ready_i) begin
         result_valid_o <= sum_valid_i;
         if (sum_valid_i) begin  // outputs hold between pulses
            result_i_o <= clamp(sum_i_i);
            result_q_o <= clamp(sum_q_i);
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/sample_pair_align.sv
`default_nettype none

module sample_pair_align (
   input  wire                   clk,
   input  wire                   arst_n_i,
   input  wire                   ready_i,
   input  wire                   x_valid_i,
   input  dot_prod_pkg::sample_t xi_i,
   input  dot_prod_pkg::sample_t xq_i,
   input  wire                   y_valid_i,
   input  dot_prod_pkg::sample_t yi_i,
   input  dot_prod_pkg::sample_t yq_i,
   output logic                  pair_valid_o,
   output dot_prod_pkg::sample_t pxi_o,
   output dot_prod_pkg::sample_t pxq_o,
   output dot_prod_pkg::sample_t pyi_o,
   output dot_prod_pkg::sample_t pyq_o
);

   dot_prod_pkg::pair_state_e state;
   dot_prod_pkg::sample_t     hxi, hxq, hyi, hyq;  // held samples
   logic                      has_x, has_y;

   // a fresh strobe counts as present, a held sample too
   assign has_x = x_valid_i || (state == dot_prod_pkg::PAIR_HAVE_X);
   assign has_y = y_valid_i || (state == dot_prod_pkg::PAIR_HAVE_Y);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state        <= dot_prod_pkg::PAIR_EMPTY;
         pair_valid_o <= 1'b0;
      end else if (ready_i) begin
         pair_valid_o <= has_x && has_y;
         if (has_x && has_y)
            state <= dot_prod_pkg::PAIR_EMPTY;
         else if (has_x)
            state <= dot_prod_pkg::PAIR_HAVE_X;
         else if (has_y)
            state <= dot_prod_pkg::PAIR_HAVE_Y;
      end
   end

   always_ff @(posedge clk) begin
      if (ready_i) begin
         if (x_valid_i) begin  // newer x replaces held one
            hxi <= xi_i;
            hxq <= xq_i;
         end
         if (y_valid_i) begin
            hyi <= yi_i;
            hyq <= yq_i;
         end
         if (has_x && has_y) begin
            pxi_o <= x_valid_i ? xi_i : hxi;
            pxq_o <= x_valid_i ? xq_i : hxq;
            pyi_o <= y_valid_i ? yi_i : hyi;
            pyq_o <= y_valid_i ? yq_i : hyq;
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/dot_prod_properties.sv
`default_nettype none

module dot_prod_properties (
   input wire clk,
   input wire arst_n_i,
   input wire ready_i,
   input wire sum_valid_i,
   input wire result_valid_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // a finished result is a single pulse unless the pipeline stalls
   single_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
      (ready_i && result_valid_i) |=> !result_valid_i)
      else $error("result_valid_o high for two cycles with ready_i high");

   quiet_in_reset: assert property (@(posedge clk)
      !arst_n_i |-> !result_valid_i)
      else $error("result_valid_o high during reset");

   // saturation stage adds one cycle
   sum_to_result: assert property (@(posedge clk) disable iff (!arst_n_i)
      (ready_i && sum_valid_i) |=> result_valid_i)
      else $error("sum_valid not followed by result_valid_o");

endmodule

bind dot_prod_top dot_prod_properties props_i (
   .clk            (clk),
   .arst_n_i       (arst_n_i),
   .ready_i        (ready_i),
   .sum_valid_i    (sum_valid),
   .result_valid_i (result_valid_o)
);

`default_nettype wire

// File: tests/dot_prod_tb.sv
`default_nettype none

`include "dot_prod_cfg.svh"

module dot_prod_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int reset_cycles = 5;
   localparam int skew_groups  = 4;
   localparam int sat_pairs    = 4 * `DP_LENGTH;
   localparam int rand_cycles  = 1500;
   localparam int drain_limit  = 60;
   localparam int max_cycles   = reset_cycles + 35 + skew_groups * 13 + sat_pairs
                                 + rand_cycles + drain_limit + 10 + 50;  // plus margin
   localparam longint res_max  = (64'sd1 <<< (`DP_RES_W - 1)) - 1;
   localparam longint res_min  = -(64'sd1 <<< (`DP_RES_W - 1));

   logic                  clk = 1'b0;
   logic                  arst_n_i, ready_i, x_valid_i, y_valid_i;
   dot_prod_pkg::sample_t xi_i, xq_i, yi_i, yq_i;
   logic                  result_valid_o;
   dot_prod_pkg::result_t result_i_o, result_q_o;

   logic [31:0] lfsr;
   int          value_errors = 0;
   int          other_errors = 0;
   int          n_results = 0;
   int          cycle_cnt = 0;
   logic        ready_seen = 1'b0;  // ready_i as the DUT saw it at the last edge
   longint      exp_i[$], exp_q[$];

   // reference model state
   logic        m_held_x = 1'b0, m_held_y = 1'b0;
   int          m_hxi, m_hxq, m_hyi, m_hyq;
   int          m_cnt = 0;
   longint      m_sum_i = 0, m_sum_q = 0;

   dot_prod_top dut_i (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .ready_i        (ready_i),
      .x_valid_i      (x_valid_i),
      .xi_i           (xi_i),
      .xq_i           (xq_i),
      .y_valid_i      (y_valid_i),
      .yi_i           (yi_i),
      .yq_i           (yq_i),
      .result_valid_o (result_valid_o),
      .result_i_o     (result_i_o),
      .result_q_o     (result_q_o)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic int rand_sample();
      return int'(dot_prod_pkg::sample_t'(take_bits(`DP_SAMPLE_W)));
   endfunction

   function automatic int full_scale();  // most positive or most negative
      return take_bits(1) ? (1 << (`DP_SAMPLE_W - 1)) - 1 : -(1 << (`DP_SAMPLE_W - 1));
   endfunction

   function automatic longint saturate(input longint v);
      return (v > res_max) ? res_max : ((v < res_min) ? res_min : v);
   endfunction

   function automatic void model_step(input logic rdy, input logic xv, input int xi,
                                      input int xq, input logic yv, input int yi, input int yq);
      int pxi, pxq, pyi, pyq;
      if (!rdy)
         return;  // stalled cycle, strobes dropped
      if ((xv || m_held_x) && (yv || m_held_y)) begin
         pxi = xv ? xi : m_hxi;
         pxq = xv ? xq : m_hxq;
         pyi = yv ? yi : m_hyi;
         pyq = yv ? yq : m_hyq;
         m_held_x = 1'b0;
         m_held_y = 1'b0;
         m_sum_i += longint'(pxi) * pyi - longint'(pxq) * pyq;
         m_sum_q += longint'(pxi) * pyq + longint'(pxq) * pyi;
         m_cnt++;
         if (m_cnt == `DP_LENGTH) begin
            exp_i.push_back(saturate(m_sum_i));
            exp_q.push_back(saturate(m_sum_q));
            m_sum_i = 0;
            m_sum_q = 0;
            m_cnt   = 0;
         end
      end else if (xv) begin  // a newer x replaces the held one
         m_held_x = 1'b1;
         m_hxi    = xi;
         m_hxq    = xq;
      end else if (yv) begin
         m_held_y = 1'b1;
         m_hyi    = yi;
         m_hyq    = yq;
      end
   endfunction

   task automatic compare(input string name, input longint expected, input longint actual);
      if (expected !== actual) begin
         value_errors++;
         $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic drive_cycle(input logic rdy, input logic xv, input int xi, input int xq,
                              input logic yv, input int yi, input int yq);
      @(posedge clk);
      #1;
      ready_i   = rdy;
      x_valid_i = xv;
      xi_i      = dot_prod_pkg::sample_t'(xi);
      xq_i      = dot_prod_pkg::sample_t'(xq);
      y_valid_i = yv;
      yi_i      = dot_prod_pkg::sample_t'(yi);
      yq_i      = dot_prod_pkg::sample_t'(yq);
      model_step(rdy, xv, xi, xq, yv, yi, yq);
   endtask

   task automatic drive_idle();
      drive_cycle(1'b1, 1'b0, 0, 0, 1'b0, 0, 0);
   endtask

   always @(posedge clk)
      ready_seen = ready_i;

   // a held result_valid_o during a stall is the same result
   always @(negedge clk) begin
      if (arst_n_i && result_valid_o && ready_seen) begin
         n_results++;
         if (exp_i.size() == 0) begin
            other_errors++;
            $display("result_valid_o pulsed at %0t ns with no result expected", $time);
         end else begin
            compare("result_i_o", exp_i.pop_front(), result_i_o);
            compare("result_q_o", exp_q.pop_front(), result_q_o);
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > max_cycles) begin
         $display("timeout, the run went past %0d cycles", max_cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      logic rdy, xv, yv;
      int   lat, g, drain;
      lfsr      = 32'h1ab7_bc42;
      arst_n_i  = 1'b0;
      ready_i   = 1'b0;
      x_valid_i = 1'b0;
      y_valid_i = 1'b0;
      xi_i      = '0;
      xq_i      = '0;
      yi_i      = '0;
      yq_i      = '0;
      repeat (reset_cycles) @(posedge clk);
      #1 arst_n_i = 1'b1;

      // no result before a full group, then fixed latency
      repeat (`DP_LENGTH - 1)
         drive_cycle(1'b1, 1'b1, rand_sample(), rand_sample(), 1'b1, rand_sample(), rand_sample());
      repeat (10) drive_idle();
      compare("results before first group", 0, n_results);
      drive_cycle(1'b1, 1'b1, rand_sample(), rand_sample(), 1'b1, rand_sample(), rand_sample());
      lat = 0;
      do begin
         drive_idle();
         lat++;
      end while (!result_valid_o && lat < 20);
      compare("result latency", 5, lat);

      for (g = 0; g < skew_groups; g++) begin
         drive_cycle(1'b1, 1'b1, rand_sample(), rand_sample(), 1'b0, 0, 0);  // x leads
         repeat (3) drive_idle();
         drive_cycle(1'b1, 1'b0, 0, 0, 1'b1, rand_sample(), rand_sample());
         drive_cycle(1'b1, 1'b0, 0, 0, 1'b1, rand_sample(), rand_sample());  // y leads
         repeat (2) drive_idle();
         drive_cycle(1'b1, 1'b1, rand_sample(), rand_sample(), 1'b0, 0, 0);
         drive_cycle(1'b1, 1'b1, rand_sample(), rand_sample(), 1'b0, 0, 0);
         drive_cycle(1'b1, 1'b1, rand_sample(), rand_sample(), 1'b0, 0, 0);  // replaces x
         drive_idle();
         drive_cycle(1'b1, 1'b0, 0, 0, 1'b1, rand_sample(), rand_sample());
      end

      repeat (sat_pairs)
         drive_cycle(1'b1, 1'b1, full_scale(), full_scale(), 1'b1, full_scale(), full_scale());

      repeat (rand_cycles) begin
         rdy = (take_bits(3) != 0);  // low one cycle in eight
         xv  = take_bits(1);
         yv  = take_bits(1);
         drive_cycle(rdy, xv, rand_sample(), rand_sample(), yv, rand_sample(), rand_sample());
      end

      drain = 0;
      while (exp_i.size() != 0 && drain < drain_limit) begin
         drive_idle();
         drain++;
      end
      repeat (10) drive_idle();

      if (exp_i.size() != 0) begin
         other_errors++;
         $display("%0d expected results never appeared", exp_i.size());
      end
      $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire
